/* pim_soc.f */
logic/pim_soc_pkg.sv
logic/word_sram.sv
logic/apb_host_port.sv
logic/sys_bus.sv
logic/pim_dma.sv
logic/pim_soc_top.sv
verification/pim_soc_tb.sv

/* verification/pim_soc_tb.sv */
`timescale 1ns/100ps

module pim_soc_tb;

    localparam int DMEM_DEPTH = 4096;
    localparam int BUF_DEPTH  = 16384;
    localparam int N_DMEM     = 16;
    localparam int N_BUF      = 8;
    localparam int COPY_LEN   = 24;
    localparam int COPY_SRC   = 200;
    localparam int COPY_DST   = 300;
    // Rough count of APB accesses over all tests
    localparam int N_ACCESS   = 3 * N_DMEM + 4 * N_BUF + 2 * COPY_LEN + 16;
    localparam int TIMEOUT_CYCLES = 4 * N_ACCESS + COPY_LEN + 100;

    logic                 clk_i = 1'b0;
    logic                 rv_rst_ni;
    logic                 psel_i;
    logic                 penable_i;
    logic                 pwrite_i;
    pim_soc_pkg::addr_t   paddr_i;
    pim_soc_pkg::word_t   pwdata_i;
    pim_soc_pkg::strb_t   pstrb_i;
    logic                 pready_o;
    pim_soc_pkg::word_t   prdata_o;
    logic                 pslverr_o;
    pim_soc_pkg::word_t   pim_addr_o;
    pim_soc_pkg::word_t   pim_wr_o;
    pim_soc_pkg::word_t   pim_rd_i;

    integer               seed = 84938;
    int                   cycle_count = 0;
    pim_soc_pkg::word_t   last_rdata;
    logic                 last_err;
    int                   last_waits;
    pim_soc_pkg::word_t   model_mem [pim_soc_pkg::addr_t];
    pim_soc_pkg::addr_t   dmem_addr [N_DMEM];
    pim_soc_pkg::addr_t   buf_ofs [N_BUF];

    pim_soc_top #(
        .DMEM_DEPTH (DMEM_DEPTH),
        .BUF_DEPTH  (BUF_DEPTH)
    ) dut_i (
        .clk_i      (clk_i),
        .rv_rst_ni  (rv_rst_ni),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .paddr_i    (paddr_i),
        .pwdata_i   (pwdata_i),
        .pstrb_i    (pstrb_i),
        .pready_o   (pready_o),
        .prdata_o   (prdata_o),
        .pslverr_o  (pslverr_o),
        .pim_addr_o (pim_addr_o),
        .pim_wr_o   (pim_wr_o),
        .pim_rd_i   (pim_rd_i)
    );

    always #4 clk_i = ~clk_i;

    task automatic end_with_failure();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input pim_soc_pkg::word_t got,
                               input pim_soc_pkg::word_t expected);
        assert (got === expected) else begin
            $display("error %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, expected);
            end_with_failure();
        end
    endtask

    // Byte lanes with strobe set take the new data
    function automatic pim_soc_pkg::word_t merge_bytes(pim_soc_pkg::word_t old_word,
                                                      pim_soc_pkg::word_t new_word,
                                                      pim_soc_pkg::strb_t strb);
        pim_soc_pkg::word_t mask;
        for (int b = 0; b < 4; b++) begin
            mask[8*b +: 8] = {8{strb[b]}};
        end
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    // One APB transfer through setup and access phase, then back to idle
    task automatic transfer(input logic wr, input pim_soc_pkg::addr_t addr,
                            input pim_soc_pkg::word_t wdata, input pim_soc_pkg::strb_t strb);
        @(negedge clk_i);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = wdata;
        pstrb_i   = wr ? strb : 4'h0;
        @(negedge clk_i);
        penable_i  = 1'b1;
        last_waits = 0;
        do begin
            @(negedge clk_i);
            last_waits++;
        end while (!pready_o);
        last_rdata = prdata_o;
        last_err   = pslverr_o;
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic write_word(input pim_soc_pkg::addr_t addr, input pim_soc_pkg::word_t data,
                              input pim_soc_pkg::strb_t strb);
        pim_soc_pkg::word_t old_word;
        old_word = model_mem.exists(addr) ? model_mem[addr] : '0;
        transfer(1'b1, addr, data, strb);
        check_value("pslverr_o", 32'(last_err), 32'd0);
        model_mem[addr] = merge_bytes(old_word, data, strb);
    endtask

    task automatic read_and_compare(input pim_soc_pkg::addr_t addr);
        transfer(1'b0, addr, '0, 4'h0);
        check_value("pslverr_o", 32'(last_err), 32'd0);
        check_value("prdata_o", last_rdata, model_mem[addr]);
    endtask

    assert property (@(posedge clk_i) disable iff (!rv_rst_ni)
                     pready_o |-> (psel_i && penable_i))
    else begin
        $display("error %0t ns: pready_o went high outside an APB access phase", $time);
        end_with_failure();
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            end_with_failure();
        end
    end

    initial begin
        pim_soc_pkg::word_t rnd;
        pim_soc_pkg::word_t pim_data;
        pim_soc_pkg::addr_t copy_addr;

        rv_rst_ni = 1'b0;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        pstrb_i   = 4'h0;
        pim_rd_i  = '0;

        repeat (3) @(negedge clk_i);
        rv_rst_ni = 1'b1;
        check_value("pready_o", 32'(pready_o), 32'd0);
        check_value("pslverr_o", 32'(pslverr_o), 32'd0);
        check_value("pim_addr_o", pim_addr_o, 32'd0);
        check_value("pim_wr_o", pim_wr_o, 32'd0);

        // Each DMEM word gets a full write so every byte is known, then a partial one
        for (int i = 0; i < N_DMEM; i++) begin
            rnd = $random(seed);
            dmem_addr[i] = rnd & 32'h0000_3ffc;
            write_word(dmem_addr[i], $random(seed), 4'hf);
            check_value("pready_o wait cycles", last_waits, 32'd1);
            rnd = $random(seed);
            write_word(dmem_addr[i], $random(seed), rnd[3:0]);
        end
        for (int i = 0; i < N_DMEM; i++) begin
            read_and_compare(dmem_addr[i]);
            check_value("pready_o wait cycles", last_waits, 32'd1);
        end

        // Same offsets in both buffers
        for (int i = 0; i < N_BUF; i++) begin
            rnd = $random(seed);
            buf_ofs[i] = rnd & 32'h0000_03fc;
            write_word(pim_soc_pkg::BUF0_BASE + buf_ofs[i], $random(seed), 4'hf);
            write_word(pim_soc_pkg::BUF1_BASE + buf_ofs[i], $random(seed), 4'hf);
        end
        for (int i = 0; i < N_BUF; i++) begin
            read_and_compare(pim_soc_pkg::BUF0_BASE + buf_ofs[i]);
            read_and_compare(pim_soc_pkg::BUF1_BASE + buf_ofs[i]);
        end

        // PIM port
        pim_data = $random(seed);
        write_word(pim_soc_pkg::PIM_BASE + 32'h0000_0120, pim_data, 4'hf);
        check_value("pim_addr_o", pim_addr_o, 32'h0000_0120);
        check_value("pim_wr_o", pim_wr_o, pim_data);
        rnd = $random(seed);
        pim_rd_i = rnd;
        transfer(1'b0, pim_soc_pkg::PIM_BASE + 32'h0000_0010, '0, 4'h0);
        check_value("pslverr_o", 32'(last_err), 32'd0);
        check_value("prdata_o", last_rdata, rnd);

        // Unmapped region
        write_word(32'h0000_0040, $random(seed), 4'hf);
        transfer(1'b1, 32'h2000_0040, $random(seed), 4'hf);
        check_value("pslverr_o", 32'(last_err), 32'd1);
        transfer(1'b0, 32'h2000_0040, '0, 4'h0);
        check_value("pslverr_o", 32'(last_err), 32'd1);
        check_value("prdata_o", last_rdata, 32'd0);
        read_and_compare(32'h0000_0040);
        check_value("pim_addr_o", pim_addr_o, 32'h0000_0120);
        check_value("pim_wr_o", pim_wr_o, pim_data);

        // Copy engine
        for (int i = 0; i < COPY_LEN; i++) begin
            write_word(pim_soc_pkg::BUF0_BASE + ((COPY_SRC + i) << 2), $random(seed), 4'hf);
        end
        write_word(pim_soc_pkg::DMA_BASE + 32'(pim_soc_pkg::DMA_SRC_OFS), COPY_SRC, 4'hf);
        write_word(pim_soc_pkg::DMA_BASE + 32'(pim_soc_pkg::DMA_DST_OFS), COPY_DST, 4'hf);
        write_word(pim_soc_pkg::DMA_BASE + 32'(pim_soc_pkg::DMA_LEN_OFS), COPY_LEN, 4'hf);
        for (int i = 0; i < COPY_LEN; i++) begin
            model_mem[pim_soc_pkg::BUF1_BASE + ((COPY_DST + i) << 2)] =
                model_mem[pim_soc_pkg::BUF0_BASE + ((COPY_SRC + i) << 2)];
        end
        transfer(1'b0, pim_soc_pkg::DMA_BASE + 32'(pim_soc_pkg::DMA_STAT_OFS), '0, 4'h0);
        check_value("prdata_o", last_rdata, 32'd1);

        // Read the last destination word while the copy still runs
        copy_addr = pim_soc_pkg::BUF1_BASE + ((COPY_DST + COPY_LEN - 1) << 2);
        read_and_compare(copy_addr);
        assert (last_waits > 1) else begin
            $display("buffer 1 read during the copy was answered without waiting");
            end_with_failure();
        end

        transfer(1'b0, pim_soc_pkg::DMA_BASE + 32'(pim_soc_pkg::DMA_STAT_OFS), '0, 4'h0);
        check_value("prdata_o", last_rdata, 32'd0);
        for (int i = 0; i < COPY_LEN; i++) begin
            read_and_compare(pim_soc_pkg::BUF1_BASE + ((COPY_DST + i) << 2));
        end

        $display("test passed");
        $finish;
    end

endmodule

/* logic/pim_soc_top.sv */
`timescale 1ns/100ps

module pim_soc_top #(
    parameter int DMEM_DEPTH = 4096,
    parameter int BUF_DEPTH  = 16384
) (
    input  logic                    clk_i,
    input  logic                    rv_rst_ni,

    // APB host port
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  pim_soc_pkg::addr_t      paddr_i,
    input  pim_soc_pkg::word_t      pwdata_i,
    input  pim_soc_pkg::strb_t      pstrb_i,
    output logic                    pready_o,
    output pim_soc_pkg::word_t      prdata_o,
    output logic                    pslverr_o,

    // PIM controller
    output pim_soc_pkg::word_t      pim_addr_o,
    output pim_soc_pkg::word_t      pim_wr_o,
    input  pim_soc_pkg::word_t      pim_rd_i
);

    pim_soc_pkg::bus_req_t  host_req;
    pim_soc_pkg::bus_rsp_t  host_rsp;
    pim_soc_pkg::bus_req_t  dma_reg_req;
    pim_soc_pkg::word_t     dma_reg_rdata;
    logic                   dma_busy;
    pim_soc_pkg::mem_req_t  dma_rd;
    pim_soc_pkg::mem_req_t  dma_wr;

    pim_soc_pkg::mem_req_t  dmem_req;
    pim_soc_pkg::mem_req_t  buf0_req;
    pim_soc_pkg::mem_req_t  buf1_req;
    pim_soc_pkg::word_t     dmem_rdata;
    pim_soc_pkg::word_t     buf0_rdata;
    pim_soc_pkg::word_t     buf1_rdata;

    apb_host_port host_port (
        .clk_i          (clk_i),
        .rv_rst_ni      (rv_rst_ni),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .paddr_i        (paddr_i),
        .pwdata_i       (pwdata_i),
        .pstrb_i        (pstrb_i),
        .pready_o       (pready_o),
        .prdata_o       (prdata_o),
        .pslverr_o      (pslverr_o),
        .host_req_o     (host_req),
        .host_rsp_i     (host_rsp)
    );

    sys_bus #(
        .DMEM_DEPTH     (DMEM_DEPTH),
        .BUF_DEPTH      (BUF_DEPTH)
    ) bus_0 (
        .clk_i          (clk_i),
        .rv_rst_ni      (rv_rst_ni),
        .host_req_i     (host_req),
        .host_rsp_o     (host_rsp),
        .dmem_req_o     (dmem_req),
        .buf0_req_o     (buf0_req),
        .buf1_req_o     (buf1_req),
        .dmem_rdata_i   (dmem_rdata),
        .buf0_rdata_i   (buf0_rdata),
        .buf1_rdata_i   (buf1_rdata),
        .dma_reg_req_o  (dma_reg_req),
        .dma_reg_rdata_i(dma_reg_rdata),
        .dma_busy_i     (dma_busy),
        .dma_rd_i       (dma_rd),
        .dma_wr_i       (dma_wr),
        .pim_addr_o     (pim_addr_o),
        .pim_wr_o       (pim_wr_o),
        .pim_rd_i       (pim_rd_i)
    );

    pim_dma #(
        .BUF_DEPTH      (BUF_DEPTH)
    ) dma_0 (
        .clk_i          (clk_i),
        .rv_rst_ni      (rv_rst_ni),
        .reg_req_i      (dma_reg_req),
        .reg_rdata_o    (dma_reg_rdata),
        .buf0_rdata_i   (buf0_rdata),
        .busy_o         (dma_busy),
        .rd_req_o       (dma_rd),
        .wr_req_o       (dma_wr)
    );

    word_sram #(
        .DEPTH          (DMEM_DEPTH)
    ) dmem_mem (
        .clk_i          (clk_i),
        .req_i          (dmem_req),
        .rdata_o        (dmem_rdata)
    );

    // Copy source
    word_sram #(
        .DEPTH          (BUF_DEPTH)
    ) buf0_mem (
        .clk_i          (clk_i),
        .req_i          (buf0_req),
        .rdata_o        (buf0_rdata)
    );

    // Copy destination
    word_sram #(
        .DEPTH          (BUF_DEPTH)
    ) buf1_mem (
        .clk_i          (clk_i),
        .req_i          (buf1_req),
        .rdata_o        (buf1_rdata)
    );

endmodule

/* logic/pim_dma.sv */
`timescale 1ns/100ps

module pim_dma #(
    parameter int BUF_DEPTH = 16384
) (
    input  logic                    clk_i,
    input  logic                    rv_rst_ni,

    // Register access from the bus
    input  pim_soc_pkg::bus_req_t   reg_req_i,
    output pim_soc_pkg::word_t      reg_rdata_o,

    // Copy path from buffer 0 to buffer 1
    input  pim_soc_pkg::word_t      buf0_rdata_i,
    output logic                    busy_o,
    output pim_soc_pkg::mem_req_t   rd_req_o,
    output pim_soc_pkg::mem_req_t   wr_req_o
);

    localparam pim_soc_pkg::addr_t IDX_MASK = pim_soc_pkg::addr_t'(BUF_DEPTH - 1);

    pim_soc_pkg::dma_state_e    state_q;
    pim_soc_pkg::addr_t         src_q;
    pim_soc_pkg::addr_t         dst_q;
    pim_soc_pkg::word_t         len_q;
    pim_soc_pkg::addr_t         rd_idx_q;
    pim_soc_pkg::addr_t         wr_idx_q;
    pim_soc_pkg::word_t         remain_q;
    logic                       wr_pend_q;
    logic [7:0]                 reg_ofs;
    logic                       reg_wr;
    pim_soc_pkg::word_t         len_new;
    logic                       start;

    function automatic pim_soc_pkg::word_t apply_strb(
        pim_soc_pkg::word_t old,
        pim_soc_pkg::word_t wdata,
        pim_soc_pkg::strb_t strb
    );
        pim_soc_pkg::word_t merged;
        merged = old;
        for (int b = 0; b < $bits(pim_soc_pkg::strb_t); b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return merged;
    endfunction

    assign reg_ofs = reg_req_i.addr[7:0];
    assign reg_wr  = reg_req_i.valid && reg_req_i.write;
    assign len_new = apply_strb(len_q, reg_req_i.wdata, reg_req_i.strb);

    // LEN write while idle kicks off the copy unless the length is zero
    assign start = reg_wr && (reg_ofs == pim_soc_pkg::DMA_LEN_OFS)
                   && (state_q == pim_soc_pkg::DMA_IDLE) && (len_new != '0);

    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            state_q   <= pim_soc_pkg::DMA_IDLE;
            src_q     <= '0;
            dst_q     <= '0;
            len_q     <= '0;
            rd_idx_q  <= '0;
            wr_idx_q  <= '0;
            remain_q  <= '0;
            wr_pend_q <= 1'b0;
        end else begin
            if (reg_wr && (reg_ofs == pim_soc_pkg::DMA_SRC_OFS)) begin
                src_q <= apply_strb(src_q, reg_req_i.wdata, reg_req_i.strb);
            end
            if (reg_wr && (reg_ofs == pim_soc_pkg::DMA_DST_OFS)) begin
                dst_q <= apply_strb(dst_q, reg_req_i.wdata, reg_req_i.strb);
            end
            if (reg_wr && (reg_ofs == pim_soc_pkg::DMA_LEN_OFS)
                && (state_q == pim_soc_pkg::DMA_IDLE)) begin
                len_q <= len_new;
            end

            // Read data lands one cycle after the read
            wr_pend_q <= (state_q == pim_soc_pkg::DMA_RUN);
            if (wr_pend_q) begin
                wr_idx_q <= (wr_idx_q + 1'b1) & IDX_MASK;
            end

            case (state_q)
                pim_soc_pkg::DMA_IDLE: begin
                    if (start) begin
                        state_q  <= pim_soc_pkg::DMA_RUN;
                        rd_idx_q <= src_q & IDX_MASK;
                        wr_idx_q <= dst_q & IDX_MASK;
                        remain_q <= len_new;
                    end
                end
                pim_soc_pkg::DMA_RUN: begin
                    rd_idx_q <= (rd_idx_q + 1'b1) & IDX_MASK;
                    remain_q <= remain_q - 1'b1;
                    if (remain_q == 32'd1) begin
                        state_q <= pim_soc_pkg::DMA_DRAIN;
                    end
                end
                pim_soc_pkg::DMA_DRAIN: begin
                    // last write goes out this cycle
                    state_q <= pim_soc_pkg::DMA_IDLE;
                end
                default: begin
                    state_q <= pim_soc_pkg::DMA_IDLE;
                end
            endcase
        end
    end

    assign busy_o = (state_q != pim_soc_pkg::DMA_IDLE);

    always_comb begin
        rd_req_o.en    = (state_q == pim_soc_pkg::DMA_RUN);
        rd_req_o.strb  = '0;
        rd_req_o.index = rd_idx_q;
        rd_req_o.wdata = '0;

        wr_req_o.en    = wr_pend_q;
        wr_req_o.strb  = wr_pend_q ? 4'hf : 4'h0;
        wr_req_o.index = wr_idx_q;
        wr_req_o.wdata = buf0_rdata_i;
    end

    always_comb begin
        case (reg_ofs)
            pim_soc_pkg::DMA_SRC_OFS:  reg_rdata_o = src_q;
            pim_soc_pkg::DMA_DST_OFS:  reg_rdata_o = dst_q;
            pim_soc_pkg::DMA_LEN_OFS:  reg_rdata_o = len_q;
            pim_soc_pkg::DMA_STAT_OFS: reg_rdata_o = {31'd0, busy_o};
            default:                   reg_rdata_o = '0;
        endcase
    end

endmodule

/* logic/sys_bus.sv */
`timescale 1ns/100ps

module sys_bus #(
    parameter int DMEM_DEPTH = 4096,
    parameter int BUF_DEPTH  = 16384
) (
    input  logic                    clk_i,
    input  logic                    rv_rst_ni,

    // Host
    input  pim_soc_pkg::bus_req_t   host_req_i,
    output pim_soc_pkg::bus_rsp_t   host_rsp_o,

    // Memories
    output pim_soc_pkg::mem_req_t   dmem_req_o,
    output pim_soc_pkg::mem_req_t   buf0_req_o,
    output pim_soc_pkg::mem_req_t   buf1_req_o,
    input  pim_soc_pkg::word_t      dmem_rdata_i,
    input  pim_soc_pkg::word_t      buf0_rdata_i,
    input  pim_soc_pkg::word_t      buf1_rdata_i,

    // Copy engine
    output pim_soc_pkg::bus_req_t   dma_reg_req_o,
    input  pim_soc_pkg::word_t      dma_reg_rdata_i,
    input  logic                    dma_busy_i,
    input  pim_soc_pkg::mem_req_t   dma_rd_i,
    input  pim_soc_pkg::mem_req_t   dma_wr_i,

    // PIM controller
    output pim_soc_pkg::word_t      pim_addr_o,
    output pim_soc_pkg::word_t      pim_wr_o,
    input  pim_soc_pkg::word_t      pim_rd_i
);

    localparam pim_soc_pkg::addr_t DMEM_MASK = pim_soc_pkg::addr_t'(DMEM_DEPTH - 1);
    localparam pim_soc_pkg::addr_t BUF_MASK  = pim_soc_pkg::addr_t'(BUF_DEPTH - 1);

    pim_soc_pkg::region_e   region;
    pim_soc_pkg::region_e   region_q;
    logic                   to_buf;
    logic                   grant;
    logic                   ready_q;
    pim_soc_pkg::addr_t     word_idx;
    pim_soc_pkg::mem_req_t  host_cmd;
    pim_soc_pkg::word_t     dma_rdata_q;
    pim_soc_pkg::word_t     rsp_rdata;

    always_comb begin
        case (host_req_i.addr[31:24])
            pim_soc_pkg::DMEM_BASE[31:24]: region = pim_soc_pkg::RGN_DMEM;
            pim_soc_pkg::BUF0_BASE[31:24]: region = pim_soc_pkg::RGN_BUF0;
            pim_soc_pkg::BUF1_BASE[31:24]: region = pim_soc_pkg::RGN_BUF1;
            pim_soc_pkg::PIM_BASE[31:24]:  region = pim_soc_pkg::RGN_PIM;
            pim_soc_pkg::DMA_BASE[31:24]:  region = pim_soc_pkg::RGN_DMA;
            default:                       region = pim_soc_pkg::RGN_NONE;
        endcase
    end

    // Buffers belong to the copy engine while it runs
    assign to_buf   = (region == pim_soc_pkg::RGN_BUF0) || (region == pim_soc_pkg::RGN_BUF1);
    assign grant    = host_req_i.valid && !(to_buf && dma_busy_i);
    assign word_idx = host_req_i.addr >> 2;

    always_comb begin
        host_cmd.en    = 1'b0;
        host_cmd.strb  = host_req_i.write ? host_req_i.strb : '0;
        host_cmd.index = '0;
        host_cmd.wdata = host_req_i.wdata;

        dmem_req_o       = host_cmd;
        dmem_req_o.en    = grant && (region == pim_soc_pkg::RGN_DMEM);
        dmem_req_o.index = word_idx & DMEM_MASK;

        buf0_req_o       = host_cmd;
        buf0_req_o.en    = grant && (region == pim_soc_pkg::RGN_BUF0);
        buf0_req_o.index = word_idx & BUF_MASK;

        buf1_req_o       = host_cmd;
        buf1_req_o.en    = grant && (region == pim_soc_pkg::RGN_BUF1);
        buf1_req_o.index = word_idx & BUF_MASK;

        if (dma_busy_i) begin
            buf0_req_o = dma_rd_i;
            buf1_req_o = dma_wr_i;
        end
    end

    always_comb begin
        dma_reg_req_o       = host_req_i;
        dma_reg_req_o.valid = grant && (region == pim_soc_pkg::RGN_DMA);
    end

    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            ready_q    <= 1'b0;
            region_q   <= pim_soc_pkg::RGN_NONE;
            pim_addr_o <= '0;
            pim_wr_o   <= '0;
        end else begin
            ready_q <= grant;
            if (grant) begin
                region_q <= region;
            end
            // PIM outputs hold until the next PIM write
            if (grant && host_req_i.write && (region == pim_soc_pkg::RGN_PIM)) begin
                pim_addr_o <= {8'h00, host_req_i.addr[23:0]};
                pim_wr_o   <= host_req_i.wdata;
            end
        end
    end

    // Register file answers combinationally, so keep it for the response cycle
    always_ff @(posedge clk_i) begin
        if (dma_reg_req_o.valid) begin
            dma_rdata_q <= dma_reg_rdata_i;
        end
    end

    always_comb begin
        case (region_q)
            pim_soc_pkg::RGN_DMEM: rsp_rdata = dmem_rdata_i;
            pim_soc_pkg::RGN_BUF0: rsp_rdata = buf0_rdata_i;
            pim_soc_pkg::RGN_BUF1: rsp_rdata = buf1_rdata_i;
            pim_soc_pkg::RGN_PIM:  rsp_rdata = pim_rd_i;
            pim_soc_pkg::RGN_DMA:  rsp_rdata = dma_rdata_q;
            default:               rsp_rdata = '0;
        endcase
        host_rsp_o.ready = ready_q;
        host_rsp_o.rdata = ready_q ? rsp_rdata : '0;
        host_rsp_o.err   = ready_q && (region_q == pim_soc_pkg::RGN_NONE);
    end

endmodule

/* logic/apb_host_port.sv */
`timescale 1ns/100ps

module apb_host_port (
    input  logic                    clk_i,
    input  logic                    rv_rst_ni,

    // APB completer side
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  pim_soc_pkg::addr_t      paddr_i,
    input  pim_soc_pkg::word_t      pwdata_i,
    input  pim_soc_pkg::strb_t      pstrb_i,
    output logic                    pready_o,
    output pim_soc_pkg::word_t      prdata_o,
    output logic                    pslverr_o,

    // System bus side
    output pim_soc_pkg::bus_req_t   host_req_o,
    input  pim_soc_pkg::bus_rsp_t   host_rsp_i
);

    logic access;
    logic done_q;

    assign access = psel_i && penable_i;

    // Set once the response was seen, cleared when the access phase ends
    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            done_q <= 1'b0;
        end else if (!access) begin
            done_q <= 1'b0;
        end else if (host_rsp_i.ready) begin
            done_q <= 1'b1;
        end
    end

    always_comb begin
        // No request in the response cycle itself
        host_req_o.valid = access && !done_q && !host_rsp_i.ready;
        host_req_o.write = pwrite_i;
        host_req_o.addr  = paddr_i;
        host_req_o.wdata = pwdata_i;
        host_req_o.strb  = pwrite_i ? pstrb_i : '0;
    end

    assign pready_o  = host_rsp_i.ready;
    assign prdata_o  = host_rsp_i.rdata;
    assign pslverr_o = host_rsp_i.err;

endmodule

/* logic/word_sram.sv */
`timescale 1ns/100ps

module word_sram #(
    parameter int DEPTH = 4096
) (
    input  logic                    clk_i,
    input  pim_soc_pkg::mem_req_t   req_i,
    output pim_soc_pkg::word_t      rdata_o
);

    localparam int AW = $clog2(DEPTH);

    pim_soc_pkg::word_t mem [DEPTH];
    logic [AW-1:0]      idx;

    assign idx = req_i.index[AW-1:0];

    // Old word comes out even when the same word is written
    always_ff @(posedge clk_i) begin
        if (req_i.en) begin
            rdata_o <= mem[idx];
            for (int b = 0; b < $bits(pim_soc_pkg::strb_t); b++) begin
                if (req_i.strb[b]) begin
                    mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

/* logic/pim_soc_pkg.sv */
package pim_soc_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  strb_t;

    // Address map with regions decoded on addr[31:24]
    localparam addr_t DMEM_BASE = 32'h0000_0000;
    localparam addr_t BUF0_BASE = 32'h1000_0000;
    localparam addr_t BUF1_BASE = 32'h1100_0000;
    localparam addr_t PIM_BASE  = 32'h4000_0000;
    localparam addr_t DMA_BASE  = 32'h4100_0000;

    // Copy engine register offsets
    localparam logic [7:0] DMA_SRC_OFS  = 8'h00;
    localparam logic [7:0] DMA_DST_OFS  = 8'h04;
    localparam logic [7:0] DMA_LEN_OFS  = 8'h08;
    localparam logic [7:0] DMA_STAT_OFS = 8'h0c;

    typedef enum logic [2:0] {
        RGN_DMEM,
        RGN_BUF0,
        RGN_BUF1,
        RGN_PIM,
        RGN_DMA,
        RGN_NONE
    } region_e;

    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
        word_t wdata;
        strb_t strb;
    } bus_req_t;

    typedef struct packed {
        logic  ready;
        word_t rdata;
        logic  err;
    } bus_rsp_t;

    // Nonzero strb means a write
    typedef struct packed {
        logic  en;
        strb_t strb;
        addr_t index;
        word_t wdata;
    } mem_req_t;

    typedef enum logic [1:0] {
        DMA_IDLE,
        DMA_RUN,
        DMA_DRAIN
    } dma_state_e;

endpackage
